// ==== text_overlay_macros.svh ====
`ifndef TEXT_OVERLAY_MACROS_SVH
`define TEXT_OVERLAY_MACROS_SVH

// visible raster
`define SCREEN_W 640
`define SCREEN_H 480

// cell buffer size in pixels, scrolling wraps here
`define WRAP_W 672
`define WRAP_H 512

// cell buffer size in 8x8 cells
`define CELL_COLS 84
`define CELL_ROWS 64

`define COLOR_W 12
`define PAL_SIZE 16

// alpha value for a fully opaque text area
`define ALPHA_FULL 6

// register map, palettes sit at 00h..3Fh below these
`define ADDR_SCROLL_X_LO 7'h40
`define ADDR_SCROLL_X_HI 7'h41
`define ADDR_SCROLL_Y_LO 7'h42
`define ADDR_SCROLL_Y_HI 7'h43
`define ADDR_CURSOR_ROW 7'h44
`define ADDR_CURSOR_COL 7'h45
`define ADDR_CELL_CHAR 7'h46
`define ADDR_CELL_COLORS 7'h47
`define ADDR_CELL_FG 7'h48
`define ADDR_CELL_BG 7'h49
`define ADDR_CELL_COMMIT 7'h4A
`define ADDR_ALPHA 7'h4B

`endif

// ==== text_overlay_pkg.sv ====
`include "text_overlay_macros.svh"

package text_overlay_pkg;

    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [`COLOR_W-1:0] color_t;

    typedef struct packed {
        logic [3:0] fg_index;
        logic [3:0] bg_index;
        logic [7:0] char_code;
    } cell_t;

    typedef enum logic [3:0] {
        OP_FG_PAL,
        OP_BG_PAL,
        OP_SCROLL_X,
        OP_SCROLL_Y,
        OP_CURSOR_ROW,
        OP_CURSOR_COL,
        OP_CELL_CHAR,
        OP_CELL_COLORS,
        OP_CELL_FG,
        OP_CELL_BG,
        OP_CELL_COMMIT,
        OP_ALPHA,
        OP_NONE
    } reg_op_e;

    typedef struct packed {
        reg_op_e op;
        logic [3:0] pal_index;
        logic hi;
        logic we;
        logic [7:0] data;
    } bus_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CELL_ACCESS,
        ST_CELL_DONE
    } fsm_state_e;

    typedef struct packed {
        logic [9:0] col;
        logic [8:0] row;
    } scan_pos_t;

    typedef struct packed {
        logic [12:0] addr;
        logic [2:0] pix_row;
        logic [2:0] pix_col;
    } cell_fetch_t;

    typedef struct packed {
        logic [7:0] char_code;
        color_t fg_color;
        color_t color;
        logic [2:0] pix_row;
        logic [2:0] pix_col;
    } pixel_t;

endpackage

// ==== bus_access_fsm.sv ====
`include "text_overlay_macros.svh"

module bus_access_fsm (
    input  logic i_rst,
    input  logic i_cpu_clk,
    input  logic i_stb,
    input  logic i_we,
    input  logic [6:0] i_addr,
    input  logic [7:0] i_data,
    output text_overlay_pkg::bus_req_t o_req,
    output logic o_req_valid,
    output logic o_cell_en,
    output logic o_cell_we,
    output logic o_cell_latch,
    output logic o_read_ack,
    output logic o_busy
);
    import text_overlay_pkg::*;

    fsm_state_e state;
    logic cell_we_q;
    logic accept;

    // address decode, palettes take the low half of the map
    always_comb begin
        o_req.pal_index = i_addr[4:1];
        o_req.hi = i_addr[0];
        o_req.we = i_we;
        o_req.data = i_data;
        o_req.op = OP_NONE;
        if (!i_addr[6]) begin
            o_req.op = i_addr[5] ? OP_BG_PAL : OP_FG_PAL;
        end else begin
            case (i_addr)
                `ADDR_SCROLL_X_LO, `ADDR_SCROLL_X_HI: o_req.op = OP_SCROLL_X;
                `ADDR_SCROLL_Y_LO, `ADDR_SCROLL_Y_HI: o_req.op = OP_SCROLL_Y;
                `ADDR_CURSOR_ROW: o_req.op = OP_CURSOR_ROW;
                `ADDR_CURSOR_COL: o_req.op = OP_CURSOR_COL;
                `ADDR_CELL_CHAR: o_req.op = OP_CELL_CHAR;
                `ADDR_CELL_COLORS: o_req.op = OP_CELL_COLORS;
                `ADDR_CELL_FG: o_req.op = OP_CELL_FG;
                `ADDR_CELL_BG: o_req.op = OP_CELL_BG;
                `ADDR_CELL_COMMIT: o_req.op = OP_CELL_COMMIT;
                `ADDR_ALPHA: o_req.op = OP_ALPHA;
                default: o_req.op = OP_NONE;
            endcase
        end
    end

    // strobes are only taken while idle
    assign accept = i_stb && (state == ST_IDLE);

    always_ff @(posedge i_rst or posedge i_cpu_clk) begin
        if (i_cpu_clk) begin
            state <= ST_IDLE;
            cell_we_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && o_req.op == OP_CELL_COMMIT) begin
                        state <= ST_CELL_ACCESS;
                        cell_we_q <= i_we;
                    end
                end
                ST_CELL_ACCESS: state <= ST_CELL_DONE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign o_req_valid = accept;
    assign o_busy = (state != ST_IDLE);
    assign o_cell_en = (state == ST_CELL_ACCESS);
    assign o_cell_we = (state == ST_CELL_ACCESS) && cell_we_q;
    assign o_cell_latch = (state == ST_CELL_DONE);

    // plain reads ack on the strobe, cell accesses once the ram data is back
    assign o_read_ack = (accept && !i_we && o_req.op != OP_CELL_COMMIT) || o_cell_latch;

endmodule

// ==== overlay_regs.sv ====
`include "text_overlay_macros.svh"

module overlay_regs (
    input  logic i_rst,
    input  logic i_cpu_clk,
    input  text_overlay_pkg::bus_req_t i_req,
    input  logic i_req_valid,
    input  logic i_cell_latch,
    input  logic i_read_ack,
    input  text_overlay_pkg::cell_t i_rd_cell,
    input  logic [3:0] i_fg_index,
    input  logic [3:0] i_bg_index,
    output logic [7:0] o_data,
    output logic o_data_ready,
    output logic [12:0] o_cell_addr,
    output text_overlay_pkg::cell_t o_put_cell,
    output logic [9:0] o_scroll_x,
    output logic [8:0] o_scroll_y,
    output text_overlay_pkg::color_t o_fg_color,
    output text_overlay_pkg::color_t o_bg_color,
    output logic [2:0] o_alpha
);
    import text_overlay_pkg::*;

    color_t fg_pal [`PAL_SIZE];
    color_t bg_pal [`PAL_SIZE];
    logic [5:0] cursor_row;
    logic [6:0] cursor_col;
    cell_t get_cell;
    logic [7:0] rd_data;
    logic [3:0] idx;

    assign idx = i_req.pal_index;

    always_ff @(posedge i_rst or posedge i_cpu_clk) begin
        if (i_cpu_clk) begin
            for (int i = 0; i < `PAL_SIZE; i++) begin
                fg_pal[i] <= '0;
                bg_pal[i] <= '0;
            end
            o_scroll_x <= '0;
            o_scroll_y <= '0;
            cursor_row <= '0;
            cursor_col <= '0;
            o_put_cell <= '0;
            get_cell <= '0;
            o_alpha <= 3'(`ALPHA_FULL);
        end else if (i_cell_latch) begin
            // ram port A is write-first, so after a commit this reloads the same word
            get_cell <= i_rd_cell;
            o_put_cell <= i_rd_cell;
        end else if (i_req_valid && i_req.we) begin
            case (i_req.op)
                OP_FG_PAL: begin
                    if (i_req.hi) begin
                        fg_pal[idx][11:8] <= i_req.data[3:0];
                    end else begin
                        fg_pal[idx][7:0] <= i_req.data;
                    end
                end
                OP_BG_PAL: begin
                    if (i_req.hi) begin
                        bg_pal[idx][11:8] <= i_req.data[3:0];
                    end else begin
                        bg_pal[idx][7:0] <= i_req.data;
                    end
                end
                OP_SCROLL_X: begin
                    if (i_req.hi) begin
                        o_scroll_x[9:8] <= i_req.data[1:0];
                    end else begin
                        o_scroll_x[7:0] <= i_req.data;
                    end
                end
                OP_SCROLL_Y: begin
                    if (i_req.hi) begin
                        o_scroll_y[8] <= i_req.data[0];
                    end else begin
                        o_scroll_y[7:0] <= i_req.data;
                    end
                end
                OP_CURSOR_ROW: cursor_row <= i_req.data[5:0];
                OP_CURSOR_COL: cursor_col <= i_req.data[6:0];
                OP_CELL_CHAR: o_put_cell.char_code <= i_req.data;
                OP_CELL_COLORS: begin
                    o_put_cell.fg_index <= i_req.data[7:4];
                    o_put_cell.bg_index <= i_req.data[3:0];
                end
                OP_CELL_FG: o_put_cell.fg_index <= i_req.data[3:0];
                OP_CELL_BG: o_put_cell.bg_index <= i_req.data[3:0];
                OP_ALPHA: o_alpha <= i_req.data[2:0];
                default: ;
            endcase
        end
    end

    // read-back mux, cell fields come from the last cell fetched at 4Ah
    always_comb begin
        case (i_req.op)
            OP_FG_PAL: rd_data = i_req.hi ? {4'h0, fg_pal[idx][11:8]} : fg_pal[idx][7:0];
            OP_BG_PAL: rd_data = i_req.hi ? {4'h0, bg_pal[idx][11:8]} : bg_pal[idx][7:0];
            OP_SCROLL_X: rd_data = i_req.hi ? {6'd0, o_scroll_x[9:8]} : o_scroll_x[7:0];
            OP_SCROLL_Y: rd_data = i_req.hi ? {7'd0, o_scroll_y[8]} : o_scroll_y[7:0];
            OP_CURSOR_ROW: rd_data = {2'd0, cursor_row};
            OP_CURSOR_COL: rd_data = {1'b0, cursor_col};
            OP_CELL_CHAR: rd_data = get_cell.char_code;
            OP_CELL_COLORS: rd_data = {get_cell.fg_index, get_cell.bg_index};
            OP_CELL_FG: rd_data = {4'h0, get_cell.fg_index};
            OP_CELL_BG: rd_data = {4'h0, get_cell.bg_index};
            OP_ALPHA: rd_data = {5'd0, o_alpha};
            default: rd_data = 8'h00;
        endcase
    end

    always_ff @(posedge i_rst or posedge i_cpu_clk) begin
        if (i_cpu_clk) begin
            o_data_ready <= 1'b0;
        end else begin
            o_data_ready <= i_read_ack;
        end
    end

    always_ff @(posedge i_rst) begin
        if (i_cell_latch) begin
            o_data <= i_rd_cell.char_code;
        end else if (i_read_ack) begin
            o_data <= rd_data;
        end
    end

    // cell address is column then row
    assign o_cell_addr = {cursor_col, cursor_row};

    // palette lookups for the pixel side
    assign o_fg_color = fg_pal[i_fg_index];
    assign o_bg_color = bg_pal[i_bg_index];

endmodule

// ==== cell_ram.sv ====
`include "text_overlay_macros.svh"

module cell_ram (
    input  logic i_rst,
    input  logic i_a_en,
    input  logic i_a_we,
    input  logic [12:0] i_a_addr,
    input  text_overlay_pkg::cell_t i_a_data,
    input  logic [12:0] i_b_addr,
    output text_overlay_pkg::cell_t o_a_data,
    output text_overlay_pkg::cell_t o_b_data
);
    import text_overlay_pkg::*;

    cell_t mem [`CELL_COLS * `CELL_ROWS];

    initial begin
        for (int i = 0; i < `CELL_COLS * `CELL_ROWS; i++) begin
            mem[i] = '0;
        end
    end

    // host port, write-first
    always_ff @(posedge i_rst) begin
        if (i_a_en) begin
            if (i_a_we) begin
                mem[i_a_addr] <= i_a_data;
                o_a_data <= i_a_data;
            end else begin
                o_a_data <= mem[i_a_addr];
            end
        end
    end

    // scan port, read only
    always_ff @(posedge i_rst) begin
        o_b_data <= mem[i_b_addr];
    end

endmodule

// ==== raster_counter.sv ====
`include "text_overlay_macros.svh"

module raster_counter (
    input  logic i_rst,
    input  logic i_cpu_clk,
    output text_overlay_pkg::scan_pos_t o_pos
);
    import text_overlay_pkg::*;

    logic col_last;
    logic row_last;

    assign col_last = (o_pos.col == 10'(`SCREEN_W - 1));
    assign row_last = (o_pos.row == 9'(`SCREEN_H - 1));

    always_ff @(posedge i_rst or posedge i_cpu_clk) begin
        if (i_cpu_clk) begin
            o_pos <= '0;
        end else if (col_last) begin
            o_pos.col <= '0;
            // row steps once per line
            o_pos.row <= row_last ? 9'd0 : o_pos.row + 9'd1;
        end else begin
            o_pos.col <= o_pos.col + 10'd1;
        end
    end

endmodule

// ==== scan_mapper.sv ====
`include "text_overlay_macros.svh"

module scan_mapper (
    input  logic i_rst,
    input  logic i_cpu_clk,
    input  text_overlay_pkg::scan_pos_t i_pos,
    input  logic [9:0] i_scroll_x,
    input  logic [8:0] i_scroll_y,
    output text_overlay_pkg::cell_fetch_t o_fetch
);
    import text_overlay_pkg::*;

    logic [10:0] sum_x;
    logic [9:0] sum_y;
    logic [10:0] wrap_x;
    logic [9:0] wrap_y;

    // one extra bit holds the carry before the wrap
    assign sum_x = {1'b0, i_pos.col} + {1'b0, i_scroll_x};
    assign sum_y = {1'b0, i_pos.row} + {1'b0, i_scroll_y};

    assign wrap_x = (sum_x >= 11'(`WRAP_W)) ? sum_x - 11'(`WRAP_W) : sum_x;
    assign wrap_y = (sum_y >= 10'(`WRAP_H)) ? sum_y - 10'(`WRAP_H) : sum_y;

    always_ff @(posedge i_rst or posedge i_cpu_clk) begin
        if (i_cpu_clk) begin
            o_fetch <= '0;
        end else begin
            // 8x8 cells, upper bits pick the cell
            o_fetch.addr <= {wrap_x[9:3], wrap_y[8:3]};
            o_fetch.pix_row <= wrap_y[2:0];
            o_fetch.pix_col <= wrap_x[2:0];
        end
    end

endmodule

// ==== pixel_colorizer.sv ====
`include "text_overlay_macros.svh"

module pixel_colorizer (
    input  logic i_rst,
    input  logic i_cpu_clk,
    input  text_overlay_pkg::cell_t i_cell,
    input  text_overlay_pkg::cell_fetch_t i_fetch_delayed,
    input  text_overlay_pkg::color_t i_fg_color,
    input  text_overlay_pkg::color_t i_bg_color,
    input  logic [2:0] i_alpha,
    input  text_overlay_pkg::color_t i_bg_in,
    output logic [3:0] o_fg_index,
    output logic [3:0] o_bg_index,
    output text_overlay_pkg::pixel_t o_pixel,
    output logic o_pix_valid
);
    import text_overlay_pkg::*;

    cell_fetch_t fetch_q;
    logic [2:0] alpha_lim;
    color_t blended;
    logic [1:0] fill;

    function automatic logic [3:0] blend_chan(input logic [3:0] top, input logic [3:0] base,
                                              input logic [2:0] a);
        logic [6:0] a_ext;
        logic [6:0] sum;
        a_ext = {4'd0, a};
        sum = {3'd0, top} * a_ext + {3'd0, base} * (7'(`ALPHA_FULL) - a_ext);
        return 4'(sum / 7'd6);
    endfunction

    assign o_fg_index = i_cell.fg_index;
    assign o_bg_index = i_cell.bg_index;

    assign alpha_lim = (i_alpha > 3'(`ALPHA_FULL)) ? 3'(`ALPHA_FULL) : i_alpha;

    // per channel blend of the cell background over the incoming colour
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            blended[ch*4 +: 4] = blend_chan(i_bg_color[ch*4 +: 4], i_bg_in[ch*4 +: 4], alpha_lim);
        end
    end

    // pixel fields trail the cell address by the ram read
    always_ff @(posedge i_rst) begin
        fetch_q <= i_fetch_delayed;
        o_pixel.char_code <= i_cell.char_code;
        o_pixel.fg_color <= i_fg_color;
        o_pixel.color <= blended;
        o_pixel.pix_row <= fetch_q.pix_row;
        o_pixel.pix_col <= fetch_q.pix_col;
    end

    // pipeline fill, valid follows the first position through mapper and ram
    always_ff @(posedge i_rst or posedge i_cpu_clk) begin
        if (i_cpu_clk) begin
            fill <= 2'b00;
            o_pix_valid <= 1'b0;
        end else begin
            fill <= {fill[0], 1'b1};
            o_pix_valid <= fill[1];
        end
    end

endmodule

// ==== text_overlay_top.sv ====
module text_overlay_top (
    input  logic i_rst,
    input  logic i_cpu_clk,
    input  logic i_stb,
    input  logic i_we,
    input  logic [6:0] i_addr,
    input  logic [7:0] i_data,
    input  text_overlay_pkg::color_t i_bg_color,
    output logic [7:0] o_data,
    output logic o_data_ready,
    output logic o_busy,
    output text_overlay_pkg::pixel_t o_pixel,
    output logic o_pix_valid
);
    import text_overlay_pkg::*;

    // host side
    bus_req_t req;
    logic req_valid;
    logic cell_en;
    logic cell_we;
    logic cell_latch;
    logic read_ack;
    logic [12:0] cell_addr;
    cell_t put_cell;
    cell_t rd_cell;

    // pixel side
    scan_pos_t pos;
    cell_fetch_t fetch;
    cell_t scan_cell;
    logic [9:0] scroll_x;
    logic [8:0] scroll_y;
    logic [2:0] alpha;
    logic [3:0] fg_index;
    logic [3:0] bg_index;
    color_t fg_color;
    color_t bg_color;

    bus_access_fsm u_bus_fsm (
        .i_rst(i_rst),
        .i_cpu_clk(i_cpu_clk),
        .i_stb(i_stb),
        .i_we(i_we),
        .i_addr(i_addr),
        .i_data(i_data),
        .o_req(req),
        .o_req_valid(req_valid),
        .o_cell_en(cell_en),
        .o_cell_we(cell_we),
        .o_cell_latch(cell_latch),
        .o_read_ack(read_ack),
        .o_busy(o_busy)
    );

    overlay_regs u_regs (
        .i_rst(i_rst),
        .i_cpu_clk(i_cpu_clk),
        .i_req(req),
        .i_req_valid(req_valid),
        .i_cell_latch(cell_latch),
        .i_read_ack(read_ack),
        .i_rd_cell(rd_cell),
        .i_fg_index(fg_index),
        .i_bg_index(bg_index),
        .o_data(o_data),
        .o_data_ready(o_data_ready),
        .o_cell_addr(cell_addr),
        .o_put_cell(put_cell),
        .o_scroll_x(scroll_x),
        .o_scroll_y(scroll_y),
        .o_fg_color(fg_color),
        .o_bg_color(bg_color),
        .o_alpha(alpha)
    );

    cell_ram u_cell_ram (
        .i_rst(i_rst),
        .i_a_en(cell_en),
        .i_a_we(cell_we),
        .i_a_addr(cell_addr),
        .i_a_data(put_cell),
        .i_b_addr(fetch.addr),
        .o_a_data(rd_cell),
        .o_b_data(scan_cell)
    );

    raster_counter u_raster (
        .i_rst(i_rst),
        .i_cpu_clk(i_cpu_clk),
        .o_pos(pos)
    );

    scan_mapper u_mapper (
        .i_rst(i_rst),
        .i_cpu_clk(i_cpu_clk),
        .i_pos(pos),
        .i_scroll_x(scroll_x),
        .i_scroll_y(scroll_y),
        .o_fetch(fetch)
    );

    pixel_colorizer u_colorizer (
        .i_rst(i_rst),
        .i_cpu_clk(i_cpu_clk),
        .i_cell(scan_cell),
        .i_fetch_delayed(fetch),
        .i_fg_color(fg_color),
        .i_bg_color(bg_color),
        .i_alpha(alpha),
        .i_bg_in(i_bg_color),
        .o_fg_index(fg_index),
        .o_bg_index(bg_index),
        .o_pixel(o_pixel),
        .o_pix_valid(o_pix_valid)
    );

endmodule

// ==== tb_text_overlay.sv ====
`include "text_overlay_macros.svh"

module tb_text_overlay;
    timeunit 1ns;
    timeprecision 1ps;

    import text_overlay_pkg::*;

    localparam int FRAME = `SCREEN_W * `SCREEN_H;

    typedef struct packed {
        logic [7:0] kind;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] d;
        logic [15:0] e;
    } step_t;

    logic i_rst;
    logic i_cpu_clk;
    logic i_stb;
    logic i_we;
    logic [6:0] i_addr;
    logic [7:0] i_data;
    color_t i_bg_color;
    logic [7:0] o_data;
    logic o_data_ready;
    logic o_busy;
    pixel_t o_pixel;
    logic o_pix_valid;

    step_t steps[$];
    int edge_cnt = 0;
    int errors = 0;
    int test_errs = 0;
    int passed = 0;
    int failed = 0;
    int n_pix = 0;
    logic loaded = 1'b0;
    logic [31:0] rand_state = 32'ha924;
    // reference copies of the scroll and alpha registers
    logic [9:0] ref_sx = '0;
    logic [8:0] ref_sy = '0;
    logic [2:0] ref_alpha = 3'd6;

    text_overlay_top i_dut (
        .i_rst(i_rst),
        .i_cpu_clk(i_cpu_clk),
        .i_stb(i_stb),
        .i_we(i_we),
        .i_addr(i_addr),
        .i_data(i_data),
        .i_bg_color(i_bg_color),
        .o_data(o_data),
        .o_data_ready(o_data_ready),
        .o_busy(o_busy),
        .o_pixel(o_pixel),
        .o_pix_valid(o_pix_valid)
    );

    initial i_rst = 1'b0;
    always #5 i_rst = ~i_rst;

    // edges counted since reset release
    // pixel n leaves the pipeline after edge n+3
    always @(posedge i_rst) begin
        if (!i_cpu_clk) begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [11:0] expected_blend(input logic [11:0] top, input logic [11:0] base,
                                                   input int a);
        logic [11:0] res;
        int lim;
        lim = (a > 6) ? 6 : a;
        for (int ch = 0; ch < 3; ch++) begin
            res[ch*4 +: 4] = 4'((int'(top[ch*4 +: 4]) * lim + int'(base[ch*4 +: 4]) * (6 - lim)) / 6);
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("at %0t ns: %s", $time, what);
            test_errs++;
        end
    endtask

    task automatic host_write(input logic [6:0] addr, input logic [7:0] data);
        @(posedge i_rst);
        i_stb <= 1'b1;
        i_we <= 1'b1;
        i_addr <= addr;
        i_data <= data;
        @(posedge i_rst);
        i_stb <= 1'b0;
        i_we <= 1'b0;
    endtask

    // counts edges from the strobe to the ready pulse
    task automatic host_read(input logic [6:0] addr, input logic [7:0] exp, input int lat);
        int k;
        logic busy_first;
        @(posedge i_rst);
        i_stb <= 1'b1;
        i_we <= 1'b0;
        i_addr <= addr;
        @(posedge i_rst);
        i_stb <= 1'b0;
        @(negedge i_rst);
        k = 1;
        busy_first = o_busy;
        while (!o_data_ready && k < 10) begin
            @(negedge i_rst);
            k++;
        end
        check_true(o_data_ready, "read never returned o_data_ready");
        check_val("read latency", 16'(k), 16'(lat));
        check_val("o_data", 16'(o_data), 16'(exp));
        if (lat == 3) begin
            check_val("o_busy", 16'(busy_first), 16'd1);
        end
        @(negedge i_rst);
        check_val("o_data_ready", 16'(o_data_ready), 16'd0);
    endtask

    task automatic wait_idle(output int k);
        k = 1;
        @(negedge i_rst);
        while (o_busy && k < 10) begin
            @(negedge i_rst);
            k++;
        end
        check_true(!o_busy, "o_busy stuck high");
    endtask

    task automatic cell_commit();
        int k;
        host_write(7'h4A, 8'h00);
        wait_idle(k);
        check_val("busy cycles", 16'(k), 16'd3);
    endtask

    // cell read at 4Ah with a second strobe while the access runs
    task automatic strobe_while_busy(input logic [6:0] addr, input logic [7:0] data);
        int k;
        @(posedge i_rst);
        i_stb <= 1'b1;
        i_we <= 1'b0;
        i_addr <= 7'h4A;
        @(posedge i_rst);
        i_we <= 1'b1;
        i_addr <= addr;
        i_data <= data;
        @(negedge i_rst);
        check_val("o_busy", 16'(o_busy), 16'd1);
        @(posedge i_rst);
        i_stb <= 1'b0;
        i_we <= 1'b0;
        wait_idle(k);
    endtask

    task automatic pixel_check(input int col, input int row, input logic [7:0] chr,
                               input color_t fg, input color_t cell_bg);
        int target;
        int x;
        int y;
        color_t bg;
        rand_state = lcg_next(rand_state);
        bg = rand_state[27:16];
        @(posedge i_rst);
        i_bg_color <= bg;
        @(negedge i_rst);
        target = 3 + row * `SCREEN_W + col;
        while (target < edge_cnt + 6) begin
            target += FRAME;
        end
        while (edge_cnt != target) begin
            @(negedge i_rst);
        end
        x = (col + ref_sx) % `WRAP_W;
        y = (row + ref_sy) % `WRAP_H;
        check_val("o_pix_valid", 16'(o_pix_valid), 16'd1);
        check_val("o_pixel.char_code", 16'(o_pixel.char_code), 16'(chr));
        check_val("o_pixel.fg_color", 16'(o_pixel.fg_color), 16'(fg));
        check_val("o_pixel.color", 16'(o_pixel.color),
                  16'(expected_blend(cell_bg, bg, int'(ref_alpha))));
        check_val("o_pixel.pix_row", 16'(o_pixel.pix_row), 16'(y % 8));
        check_val("o_pixel.pix_col", 16'(o_pixel.pix_col), 16'(x % 8));
    endtask

    task automatic load_steps();
        int fd;
        int n;
        string line;
        string code;
        int a;
        int b;
        int c;
        int d;
        int e;
        step_t s;
        fd = $fopen("text_overlay_stimulus.txt", "r");
        check_true(fd != 0, "cannot open text_overlay_stimulus.txt");
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            code = "";
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                e = 0;
                if (line[0] == "P") begin
                    n = $sscanf(line, "%s %d %d %h %h %h", code, a, b, c, d, e);
                    n_pix++;
                end else begin
                    n = $sscanf(line, "%s %h %h", code, a, b);
                end
                s.kind = line[0];
                s.a = 16'(a);
                s.b = 16'(b);
                s.c = 16'(c);
                s.d = 16'(d);
                s.e = 16'(e);
                steps.push_back(s);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // watchdog allows two frames per pixel check and 100 cycles per step
    initial begin
        wait (loaded);
        repeat (n_pix * 2 * FRAME + 100 * (steps.size() + 1)) @(posedge i_rst);
        $display("timeout, the run did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        i_cpu_clk = 1'b1;
        i_stb = 1'b0;
        i_we = 1'b0;
        i_addr = '0;
        i_data = '0;
        i_bg_color = '0;
        load_steps();
        loaded = 1'b1;
        @(negedge i_rst);
        check_val("o_busy", 16'(o_busy), 16'd0);
        check_val("o_data_ready", 16'(o_data_ready), 16'd0);
        check_val("o_pix_valid", 16'(o_pix_valid), 16'd0);
        repeat (2) @(posedge i_rst);
        i_cpu_clk <= 1'b0;
        errors += test_errs;
        for (int i = 0; i < steps.size(); i++) begin
            test_errs = 0;
            case (steps[i].kind)
                "W": begin
                    host_write(7'(steps[i].a), 8'(steps[i].b));
                    case (steps[i].a)
                        16'h40: ref_sx[7:0] = steps[i].b[7:0];
                        16'h41: ref_sx[9:8] = steps[i].b[1:0];
                        16'h42: ref_sy[7:0] = steps[i].b[7:0];
                        16'h43: ref_sy[8] = steps[i].b[0];
                        16'h4B: ref_alpha = steps[i].b[2:0];
                        default: ;
                    endcase
                end
                "R": host_read(7'(steps[i].a), 8'(steps[i].b), (steps[i].a == 16'h4A) ? 3 : 1);
                "C": cell_commit();
                "B": strobe_while_busy(7'(steps[i].a), 8'(steps[i].b));
                "P": pixel_check(int'(steps[i].a), int'(steps[i].b), 8'(steps[i].c),
                                 12'(steps[i].d), 12'(steps[i].e));
                default: check_true(1'b0, "unknown step kind in stimulus file");
            endcase
            if (test_errs == 0) begin
                passed++;
                $display("test %0d (%c): ok", i, steps[i].kind);
            end else begin
                failed++;
                $display("test %0d (%c): FAILED", i, steps[i].kind);
            end
            errors += test_errs;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", steps.size(), passed,
                 failed, errors);
        if (errors == 0 && steps.size() > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== text_overlay_stimulus.txt ====
# W addr data | R addr expected | C (commit at 4A) | B addr data (write while busy)
# P col row char fg_color cell_bg_color (col and row decimal, rest hex)
W 02 bc
W 03 0a
R 02 bc
R 03 0a
W 03 fa
R 03 0a
W 24 e7
W 25 05
R 25 05
W 40 13
W 41 ff
R 40 13
R 41 03
W 40 00
W 41 00
W 44 05
W 45 0a
W 47 12
W 46 41
C
R 4a 41
R 47 12
B 40 55
R 40 00
P 83 42 41 abc 5e7
W 4b 03
P 80 40 41 abc 5e7
W 4b 00
P 87 47 41 abc 5e7
W 4b 06
W 40 80
W 41 02
W 42 f4
W 43 01
P 112 52 41 abc 5e7
P 115 55 41 abc 5e7
P 0 0 00 000 000

// ==== sources.f ====
+incdir+.
text_overlay_pkg.sv
bus_access_fsm.sv
overlay_regs.sv
cell_ram.sv
raster_counter.sv
scan_mapper.sv
pixel_colorizer.sv
text_overlay_top.sv
tb_text_overlay.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= sources.f
TB_TOP ?= tb_text_overlay
RTL_TOP ?= text_overlay_top
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
